/* Makefile */
# Verilator build and run of the aesLanes testbench

VERILATOR ?= verilator
TOP       ?= aesLanesTb
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# Exit status of the binary is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

/* filelist.f */
src/aesPkg.sv
src/cipherBusIf.sv
src/aesIngress.sv
src/aesRound.sv
src/aesCore.sv
src/aesEgress.sv
src/aesLanes.sv
tests/aesLanes_chk.sv
tests/aesLanesTb.sv

/* src/aesCore.sv */
// ----------------------------------------------------------------------
// One fully pipelined AES-128 encryption lane
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module aesCore (
   input  logic                          Clock,
   input  logic [aesPkg::blockWidth-1:0] plainText,
   input  logic [aesPkg::blockWidth-1:0] key,
   output logic [aesPkg::blockWidth-1:0] cipherText
);
   import aesPkg::*;

   // Round constants for rounds 1 to 10
   localparam logic [7:0] rconTable [roundCount] = '{
      8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
   };

   // Entry 0 is the combinational input, entry r the output of round r
   logic [blockWidth-1:0] stateChain [roundCount+1];
   logic [blockWidth-1:0] keyChain [roundCount+1];

   // Initial AddRoundKey
   assign stateChain[0] = plainText ^ key;
   assign keyChain[0] = key;

   for (genvar r = 0; r < roundCount; r++) begin : gRound
      aesRound #(
         .kind((r == roundCount - 1) ? roundFinal : roundMiddle)
      ) round (
         .Clock      (Clock),
         .stateIn    (stateChain[r]),
         .roundKeyIn (keyChain[r]),
         .rcon       (rconTable[r]),
         .stateOut   (stateChain[r+1]),
         .roundKeyOut(keyChain[r+1])
      );
   end

   assign cipherText = stateChain[roundCount];

endmodule

`default_nettype wire

/* src/aesEgress.sv */
// ----------------------------------------------------------------------
// Valid delay line and output register for the wide result
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module aesEgress #(
   parameter int lanes = 4
) (
   input  logic                                Clock,
   input  logic                                reset,
   cipherBusIf.egress                          bus,
   output logic [lanes*aesPkg::blockWidth-1:0] DataOut,
   output logic                                DataOutValid
);
   import aesPkg::*;

   // Bit k is the ingress strobe delayed by k+1 cycles
   logic [coreLatency-1:0] validLine;

   // ---------------------------------------------------------------------
   // Control
   // ---------------------------------------------------------------------
   always_ff @(posedge Clock) begin
      if (reset) begin
         validLine <= '0;
         DataOutValid <= 1'b0;
      end else begin
         validLine <= {validLine[coreLatency-2:0], bus.valid};
         // Top bit lines up with the lane results
         DataOutValid <= validLine[coreLatency-1];
      end
   end

   // ---------------------------------------------------------------------
   // Payload
   // ---------------------------------------------------------------------

   // Lane 0 lands in the lowest bits
   always_ff @(posedge Clock) begin
      DataOut <= bus.results;
   end

endmodule

`default_nettype wire

/* src/aesIngress.sv */
// ----------------------------------------------------------------------
// Input join of data and key, lane tagging and input registers
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module aesIngress #(
   parameter int lanes = 4,
   parameter int entropyWidth = 64
) (
   input  logic                          Clock,
   input  logic                          reset,
   input  logic [entropyWidth-1:0]       DataIn,
   input  logic                          DataInValid,
   output logic                          DataInReady,
   input  logic [aesPkg::blockWidth-1:0] Key,
   input  logic                          KeyValid,
   output logic                          KeyReady,
   cipherBusIf.ingress                   bus
);
   import aesPkg::*;

   // Upper bits of each plaintext hold the lane index
   localparam int tagWidth = blockWidth - entropyWidth;

   logic accept;

   // Both sides must offer in the same cycle
   assign accept = DataInValid & KeyValid;

   // Pipeline never stalls, so each ready is the other side's valid
   assign DataInReady = KeyValid;
   assign KeyReady = DataInValid;

   // One strobe per accepted pair
   always_ff @(posedge Clock) begin
      if (reset) begin
         bus.valid <= 1'b0;
      end else begin
         bus.valid <= accept;
      end
   end

   // Payload registers, loaded on acceptance only
   always_ff @(posedge Clock) begin
      if (accept) begin
         bus.key <= Key;
         for (int l = 0; l < lanes; l++) begin
            // Zero-extended lane index above the data word
            bus.blocks[l] <= {tagWidth'(l), DataIn};
         end
      end
   end

endmodule

`default_nettype wire

/* src/aesLanes.sv */
// ----------------------------------------------------------------------
// Multi-lane AES-128 front end: ingress, cipher lanes and egress
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module aesLanes #(
   parameter int lanes = 4,
   parameter int entropyWidth = 64
) (
   input  logic                                Clock,
   input  logic                                reset,
   input  logic [entropyWidth-1:0]             DataIn,
   input  logic                                DataInValid,
   output logic                                DataInReady,
   input  logic [aesPkg::blockWidth-1:0]       Key,
   input  logic                                KeyValid,
   output logic                                KeyReady,
   output logic [lanes*aesPkg::blockWidth-1:0] DataOut,
   output logic                                DataOutValid
);
   import aesPkg::*;

   cipherBusIf #(.lanes(lanes)) bus ();

   // Join and lane tagging
   aesIngress #(
      .lanes       (lanes),
      .entropyWidth(entropyWidth)
   ) ingress (
      .Clock      (Clock),
      .reset      (reset),
      .DataIn     (DataIn),
      .DataInValid(DataInValid),
      .DataInReady(DataInReady),
      .Key        (Key),
      .KeyValid   (KeyValid),
      .KeyReady   (KeyReady),
      .bus        (bus.ingress)
   );

   // One cipher per lane, all sharing the key
   for (genvar l = 0; l < lanes; l++) begin : gLane
      aesCore core (
         .Clock     (Clock),
         .plainText (bus.blocks[l]),
         .key       (bus.key),
         .cipherText(bus.results[l])
      );
   end

   // Validity tracking and wide output
   aesEgress #(
      .lanes(lanes)
   ) egress (
      .Clock       (Clock),
      .reset       (reset),
      .bus         (bus.egress),
      .DataOut     (DataOut),
      .DataOutValid(DataOutValid)
   );

endmodule

`default_nettype wire

/* src/aesPkg.sv */
// ----------------------------------------------------------------------
// Shared AES-128 constants, the round-kind enum and the S-box and
// GF(2^8) arithmetic helpers
// ----------------------------------------------------------------------
`default_nettype none

package aesPkg;

   // Block and key width
   localparam int blockWidth = 128;
   // Rounds of AES-128
   localparam int roundCount = 10;
   // One pipeline stage per round
   localparam int coreLatency = roundCount;
   // Ingress register + lane + egress register
   localparam int totalLatency = coreLatency + 2;

   // Final round has no MixColumns
   typedef enum logic {
      roundMiddle,
      roundFinal
   } roundKind_t;

   // ---------------------------------------------------------------------
   // GF(2^8) arithmetic, polynomial x^8 + x^4 + x^3 + x + 1
   // ---------------------------------------------------------------------

   // Multiply by 2
   function automatic logic [7:0] xtime(input logic [7:0] a);
      return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
   endfunction

   // Shift-and-add multiply
   function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
      logic [7:0] prod;
      logic [7:0] acc;
      prod = 8'h00;
      acc = a;
      for (int i = 0; i < 8; i++) begin
         if (b[i]) begin
            prod = prod ^ acc;
         end
         acc = xtime(acc);
      end
      return prod;
   endfunction

   // S-box: inverse as x^254, then affine transform
   function automatic logic [7:0] sbox(input logic [7:0] x);
      logic [7:0] power;
      logic [7:0] inv;
      logic [7:0] res;
      power = x;
      inv = 8'h01;
      // x^254 = x^2 * x^4 * ... * x^128
      for (int k = 1; k < 8; k++) begin
         power = gfMul(power, power);
         inv = gfMul(inv, power);
      end
      // Affine transform, constant 0x63
      for (int i = 0; i < 8; i++) begin
         res[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
                ^ inv[(i + 7) % 8];
      end
      return res ^ 8'h63;
   endfunction

endpackage

`default_nettype wire

/* src/aesRound.sv */
// ----------------------------------------------------------------------
// One AES round with its key-expansion step, registered as one stage
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module aesRound #(
   parameter aesPkg::roundKind_t kind = aesPkg::roundMiddle
) (
   input  logic                          Clock,
   input  logic [aesPkg::blockWidth-1:0] stateIn,
   input  logic [aesPkg::blockWidth-1:0] roundKeyIn,
   input  logic [7:0]                    rcon,
   output logic [aesPkg::blockWidth-1:0] stateOut,
   output logic [aesPkg::blockWidth-1:0] roundKeyOut
);
   import aesPkg::*;

   // Byte 0 sits in the top bits, column-major as in FIPS-197
   logic [0:15][7:0] inBytes;
   logic [0:15][7:0] subBytes;
   logic [0:15][7:0] shifted;
   logic [0:15][7:0] mixed;
   logic [0:15][7:0] roundOut;
   logic [0:3][31:0] keyWords;
   logic [0:3][31:0] nextWords;
   logic [31:0]      rotSub;

   // ---------------------------------------------------------------------
   // Key expansion
   // ---------------------------------------------------------------------
   always_comb begin
      keyWords = roundKeyIn;
      // SubWord(RotWord(w3)) with round constant in the top byte
      rotSub = {sbox(keyWords[3][23:16]), sbox(keyWords[3][15:8]),
                sbox(keyWords[3][7:0]), sbox(keyWords[3][31:24])};
      rotSub[31:24] = rotSub[31:24] ^ rcon;
      // XOR chain across the four words
      nextWords[0] = keyWords[0] ^ rotSub;
      nextWords[1] = keyWords[1] ^ nextWords[0];
      nextWords[2] = keyWords[2] ^ nextWords[1];
      nextWords[3] = keyWords[3] ^ nextWords[2];
   end

   // ---------------------------------------------------------------------
   // State transform
   // ---------------------------------------------------------------------
   always_comb begin
      inBytes = stateIn;
      for (int i = 0; i < 16; i++) begin
         subBytes[i] = sbox(inBytes[i]);
      end
      // Row r rotates left by r columns
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++) begin
            shifted[4 * c + r] = subBytes[4 * ((c + r) % 4) + r];
         end
      end
      // MixColumns, 3a written as xtime(a) ^ a
      for (int c = 0; c < 4; c++) begin
         mixed[4 * c] = xtime(shifted[4 * c]) ^ xtime(shifted[4 * c + 1])
                      ^ shifted[4 * c + 1] ^ shifted[4 * c + 2] ^ shifted[4 * c + 3];
         mixed[4 * c + 1] = shifted[4 * c] ^ xtime(shifted[4 * c + 1])
                          ^ xtime(shifted[4 * c + 2]) ^ shifted[4 * c + 2]
                          ^ shifted[4 * c + 3];
         mixed[4 * c + 2] = shifted[4 * c] ^ shifted[4 * c + 1]
                          ^ xtime(shifted[4 * c + 2]) ^ xtime(shifted[4 * c + 3])
                          ^ shifted[4 * c + 3];
         mixed[4 * c + 3] = xtime(shifted[4 * c]) ^ shifted[4 * c] ^ shifted[4 * c + 1]
                          ^ shifted[4 * c + 2] ^ xtime(shifted[4 * c + 3]);
      end
      // Last round skips MixColumns
      roundOut = (kind == roundFinal) ? shifted : mixed;
   end

   // AddRoundKey with the fresh key; key moves in step with the state
   always_ff @(posedge Clock) begin
      stateOut <= roundOut ^ nextWords;
      roundKeyOut <= nextWords;
   end

endmodule

`default_nettype wire

/* src/cipherBusIf.sv */
// ----------------------------------------------------------------------
// Internal bus between ingress, cipher lanes and egress
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface cipherBusIf #(
   parameter int lanes = 4
);
   import aesPkg::*;

   // Tagged plaintexts, lane 0 in the low bits
   logic [lanes-1:0][blockWidth-1:0] blocks;
   // Key shared by all lanes
   logic [blockWidth-1:0] key;
   // Registered acceptance strobe
   logic valid;
   // Ciphertexts, same layout as blocks
   logic [lanes-1:0][blockWidth-1:0] results;

   modport ingress (
      output blocks, key, valid
   );

   // Each lane picks its own slice
   modport lane (
      input blocks, key,
      output results
   );

   modport egress (
      input valid, results
   );

endinterface

`default_nettype wire

/* tests/aesLanesTb.sv */
// ----------------------------------------------------------------------
// Table-driven testbench for aesLanes with a behavioral AES-128 model,
// an in-order scoreboard and the value check task
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module aesLanesTb;
   import aesPkg::*;

   localparam int lanes = 4;
   localparam int entropyWidth = 64;
   localparam int tagWidth = blockWidth - entropyWidth;
   // Falling edges from driving an entry to seeing its result
   localparam int latency = 12;
   localparam int entryCount = 48;
   localparam int drainLimit = latency + 8;
   // FIPS-197 AES-128 of an all-zero block under an all-zero key
   localparam logic [blockWidth-1:0] knownAnswer = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
   // Valid patterns of the join-rule entries, bit j for entry 8 + j
   localparam logic [7:0] joinDataValid = 8'b0110_1001;
   localparam logic [7:0] joinKeyValid = 8'b0101_1010;

   typedef struct packed {
      logic [blockWidth-1:0]   key;
      logic [entropyWidth-1:0] data;
      logic                    dataValid;
      logic                    keyValid;
   } entry_t;

   typedef struct packed {
      logic [lanes*blockWidth-1:0] result;
      int                          dueCycle;
   } expect_t;

   logic                          Clock = 1'b0;
   logic                          reset;
   logic [entropyWidth-1:0]       DataIn;
   logic                          DataInValid;
   logic                          DataInReady;
   logic [blockWidth-1:0]         Key;
   logic                          KeyValid;
   logic                          KeyReady;
   logic [lanes*blockWidth-1:0]   DataOut;
   logic                          DataOutValid;

   entry_t  stimTable [entryCount];
   expect_t pending [$];
   int      seed;
   int      cycle = 0;

   aesLanes #(
      .lanes       (lanes),
      .entropyWidth(entropyWidth)
   ) dut (
      .Clock       (Clock),
      .reset       (reset),
      .DataIn      (DataIn),
      .DataInValid (DataInValid),
      .DataInReady (DataInReady),
      .Key         (Key),
      .KeyValid    (KeyValid),
      .KeyReady    (KeyReady),
      .DataOut     (DataOut),
      .DataOutValid(DataOutValid)
   );

   // 8 ns period
   always #4 Clock = ~Clock;

   task automatic failRun(input string reason);
      $display("%s", reason);
      $display("Simulation failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic checkValue(input string name, input logic [blockWidth-1:0] actual,
                             input logic [blockWidth-1:0] expected);
      if (actual !== expected) begin
         failRun($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected));
      end
   endtask

   // ---------------------------------------------------------------------
   // Behavioral AES-128 with the state held as rows by columns
   // ---------------------------------------------------------------------
   function automatic logic [7:0] doubleByte(input logic [7:0] b);
      return (b << 1) ^ (b[7] ? 8'h1b : 8'h00);
   endfunction

   function automatic logic [7:0] tripleByte(input logic [7:0] b);
      return doubleByte(b) ^ b;
   endfunction

   function automatic logic [blockWidth-1:0] aesEncrypt(input logic [blockWidth-1:0] key,
                                                        input logic [blockWidth-1:0] plain);
      logic [31:0]           w [44];
      logic [31:0]           temp;
      logic [7:0]            rc;
      logic [7:0]            s [4][4];
      logic [7:0]            t [4][4];
      logic [7:0]            a [4];
      logic [blockWidth-1:0] out;
      // Full key schedule of 44 words up front
      for (int i = 0; i < 4; i++) begin
         w[i] = key[127 - 32 * i -: 32];
      end
      rc = 8'h01;
      for (int i = 4; i < 44; i++) begin
         temp = w[i - 1];
         if (i % 4 == 0) begin
            temp = {sbox(temp[23:16]), sbox(temp[15:8]), sbox(temp[7:0]), sbox(temp[31:24])}
                 ^ {rc, 24'h000000};
            rc = doubleByte(rc);
         end
         w[i] = w[i - 4] ^ temp;
      end
      // Byte b of the block is row b%4, column b/4
      for (int b = 0; b < 16; b++) begin
         s[b % 4][b / 4] = plain[127 - 8 * b -: 8] ^ w[b / 4][31 - 8 * (b % 4) -: 8];
      end
      for (int rnd = 1; rnd <= 10; rnd++) begin
         for (int b = 0; b < 16; b++) begin
            t[b % 4][b / 4] = sbox(s[b % 4][b / 4]);
         end
         for (int b = 0; b < 16; b++) begin
            s[b % 4][b / 4] = t[b % 4][(b / 4 + b % 4) % 4];
         end
         if (rnd != 10) begin
            for (int c = 0; c < 4; c++) begin
               for (int r = 0; r < 4; r++) begin
                  a[r] = s[r][c];
               end
               s[0][c] = doubleByte(a[0]) ^ tripleByte(a[1]) ^ a[2] ^ a[3];
               s[1][c] = a[0] ^ doubleByte(a[1]) ^ tripleByte(a[2]) ^ a[3];
               s[2][c] = a[0] ^ a[1] ^ doubleByte(a[2]) ^ tripleByte(a[3]);
               s[3][c] = tripleByte(a[0]) ^ a[1] ^ a[2] ^ doubleByte(a[3]);
            end
         end
         for (int b = 0; b < 16; b++) begin
            s[b % 4][b / 4] = s[b % 4][b / 4] ^ w[4 * rnd + b / 4][31 - 8 * (b % 4) -: 8];
         end
      end
      for (int b = 0; b < 16; b++) begin
         out[127 - 8 * b -: 8] = s[b % 4][b / 4];
      end
      return out;
   endfunction

   // ---------------------------------------------------------------------
   // Stimulus table
   // ---------------------------------------------------------------------
   task automatic fillTable();
      logic [31:0] r;
      // Entry 0 is the known-answer case
      stimTable[0] = '{key: '0, data: '0, dataValid: 1'b1, keyValid: 1'b1};
      // Back-to-back accepts
      for (int i = 1; i < 8; i++) begin
         stimTable[i].key = 128'h000102030405060708090a0b0c0d0e0f ^ {16{8'(i)}};
         stimTable[i].data = 64'h0011223344556677 + 64'(i);
         stimTable[i].dataValid = 1'b1;
         stimTable[i].keyValid = 1'b1;
      end
      // Join rule with one side, neither side or both sides valid
      for (int j = 0; j < 8; j++) begin
         stimTable[8 + j].key = {$random(seed), $random(seed), $random(seed), $random(seed)};
         stimTable[8 + j].data = {$random(seed), $random(seed)};
         stimTable[8 + j].dataValid = joinDataValid[j];
         stimTable[8 + j].keyValid = joinKeyValid[j];
      end
      // Seeded random tail with mostly accepting entries
      for (int i = 16; i < entryCount; i++) begin
         r = $random(seed);
         stimTable[i].key = {$random(seed), $random(seed), $random(seed), $random(seed)};
         stimTable[i].data = {$random(seed), $random(seed)};
         stimTable[i].dataValid = r[0] | r[1];
         stimTable[i].keyValid = r[2] | r[3];
      end
   endtask

   // Readies are combinational on stable inputs at the rising edge
   always @(posedge Clock) begin
      cycle <= cycle + 1;
      checkValue("DataInReady", 128'(DataInReady), 128'(KeyValid));
      checkValue("KeyReady", 128'(KeyReady), 128'(DataInValid));
   end

   // Outputs settle after the rising edge
   always @(negedge Clock) begin : outputMonitor
      logic    expectedValid;
      expect_t front;
      expectedValid = 1'b0;
      if (pending.size() != 0) begin
         expectedValid = (pending[0].dueCycle == cycle);
      end
      checkValue("DataOutValid", 128'(DataOutValid), 128'(expectedValid));
      if (expectedValid) begin
         front = pending.pop_front();
         for (int l = 0; l < lanes; l++) begin
            checkValue($sformatf("DataOut lane %0d", l), DataOut[l*blockWidth +: blockWidth],
                       front.result[l*blockWidth +: blockWidth]);
         end
         // Distinct tags must give distinct ciphertexts
         for (int l = 0; l < lanes; l++) begin
            for (int m = l + 1; m < lanes; m++) begin
               if (DataOut[l*blockWidth +: blockWidth] == DataOut[m*blockWidth +: blockWidth]) begin
                  failRun($sformatf("lanes %0d and %0d returned the same block", l, m));
               end
            end
         end
      end
   end

   initial begin : driver
      expect_t item;
      int      waited;
      seed = 32'h3df5_c8c1;
      reset = 1'b1;
      DataIn = '0;
      DataInValid = 1'b0;
      Key = '0;
      KeyValid = 1'b0;
      // Model against the published vector first
      checkValue("model known answer", aesEncrypt('0, '0), knownAnswer);
      fillTable();
      repeat (5) @(posedge Clock);
      @(negedge Clock);
      reset = 1'b0;

      for (int i = 0; i < entryCount; i++) begin
         @(negedge Clock);
         DataIn = stimTable[i].data;
         Key = stimTable[i].key;
         DataInValid = stimTable[i].dataValid;
         KeyValid = stimTable[i].keyValid;
         if (stimTable[i].dataValid && stimTable[i].keyValid) begin
            item.dueCycle = cycle + latency;
            for (int l = 0; l < lanes; l++) begin
               item.result[l*blockWidth +: blockWidth] =
                  aesEncrypt(stimTable[i].key, {tagWidth'(l), stimTable[i].data});
            end
            if (i == 0) begin
               item.result[blockWidth-1:0] = knownAnswer;
            end
            pending.push_back(item);
         end
      end

      @(negedge Clock);
      DataInValid = 1'b0;
      KeyValid = 1'b0;
      // Drain the pipeline
      waited = 0;
      while (pending.size() != 0) begin
         @(negedge Clock);
         waited++;
         if (waited > drainLimit) begin
            failRun("timed out waiting for output");
         end
      end
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

/* tests/aesLanes_chk.sv */
// ----------------------------------------------------------------------
// Bound assertions on latency, ready rule and reset of aesLanes
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module aesLanes_chk (
   input logic Clock,
   input logic reset,
   input logic DataInValid,
   input logic DataInReady,
   input logic KeyValid,
   input logic KeyReady,
   input logic DataOutValid
);
   // Cycles since reset, saturates at the pipeline depth
   logic [3:0] settled;

   always_ff @(posedge Clock) begin
      if (reset) begin
         settled <= '0;
      end else if (settled != 4'd12) begin
         settled <= settled + 4'd1;
      end
   end

   // Output strobe is the acceptance 12 cycles back
   latencyMatch: assert property (@(posedge Clock) disable iff (reset || settled != 4'd12)
      DataOutValid == $past(DataInValid && KeyValid, 12))
      else $error("output strobe does not follow acceptance by 12 cycles");

   // Each ready mirrors the other side's valid
   readyRule: assert property (@(posedge Clock)
      (DataInReady == KeyValid) && (KeyReady == DataInValid))
      else $error("ready outputs break the join rule");

   resetClears: assert property (@(posedge Clock) reset |=> !DataOutValid)
      else $error("output strobe high right after reset");

endmodule

bind aesLanes aesLanes_chk chk (
   .Clock       (Clock),
   .reset       (reset),
   .DataInValid (DataInValid),
   .DataInReady (DataInReady),
   .KeyValid    (KeyValid),
   .KeyReady    (KeyReady),
   .DataOutValid(DataOutValid)
);

`default_nettype wire
